//--- pkt_fifo_consts.svh
// packet FIFO widths, depths and latencies

`ifndef PKT_FIFO_CONSTS_SVH
`define PKT_FIFO_CONSTS_SVH

// buffer geometry
`define PKT_ADDR_WID    6   // 64 RAM entries
`define PKT_DATA_BYTES  4

// sideband widths
`define PKT_TID_WID     4
`define PKT_TDEST_WID   4
`define PKT_TUSER_WID   4

`define PKT_SKID_DEPTH  4   // output FIFO entries

`define PKT_RAM_WR_LAT  2   // input register plus array write
`define PKT_RAM_RD_LAT  1

`endif

//--- pkt_fifo_pkg.sv
// packet FIFO types

`include "pkt_fifo_consts.svh"

package pkt_fifo_pkg;

   typedef logic [`PKT_DATA_BYTES*8-1:0] tdata_t;
   typedef logic [`PKT_DATA_BYTES-1:0]   tkeep_t;
   typedef logic [`PKT_TID_WID-1:0]      tid_t;
   typedef logic [`PKT_TDEST_WID-1:0]    tdest_t;
   typedef logic [`PKT_TUSER_WID-1:0]    tuser_t;

   // msb is the wrap bit, tells full from empty
   typedef logic [`PKT_ADDR_WID:0] ptr_t;

   // {tlast, tid, tdest, tuser, tkeep, tdata}
   typedef logic [`PKT_TID_WID+`PKT_TDEST_WID+`PKT_TUSER_WID+`PKT_DATA_BYTES*9:0] mem_word_t;

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_STREAM,
      RD_WAIT_CREDIT
   } rd_state_t;

endpackage

//--- sdp_ram.sv
// simple dual-port RAM
`timescale 1ns/10ps

`include "pkt_fifo_consts.svh"

module sdp_ram (
   input  logic                      axi4s_in,
   input  logic                      srst,
   input  logic                      wr_req,
   input  logic [`PKT_ADDR_WID-1:0]  wr_addr,
   input  pkt_fifo_pkg::mem_word_t   wr_data,
   input  logic                      rd_req,
   input  logic [`PKT_ADDR_WID-1:0]  rd_addr,
   output pkt_fifo_pkg::mem_word_t   rd_data
);

   import pkt_fifo_pkg::*;

   mem_word_t mem [2**`PKT_ADDR_WID];

   logic                      wr_req_r;
   logic [`PKT_ADDR_WID-1:0]  wr_addr_r;
   mem_word_t                 wr_data_r;

   // write input stage
   always_ff @(posedge axi4s_in) begin
      if (srst) begin
         wr_req_r <= 1'b0;
      end else begin
         wr_req_r <= wr_req;
      end
      wr_addr_r <= wr_addr;
      wr_data_r <= wr_data;
   end

   always_ff @(posedge axi4s_in) begin
      if (wr_req_r) mem[wr_addr_r] <= wr_data_r;   // second write cycle
   end

   always_ff @(posedge axi4s_in) begin
      if (rd_req) rd_data <= mem[rd_addr];   // old data if the write is still in flight
   end

endmodule

//--- pkt_buffer.sv
// pipelined packet buffer
`timescale 1ns/10ps

`include "pkt_fifo_consts.svh"

module pkt_buffer (
   input  logic                   axi4s_in,
   input  logic                   srst,

   input  logic                   in_tvalid,
   input  logic                   in_tready,
   input  pkt_fifo_pkg::tdata_t   in_tdata,
   input  pkt_fifo_pkg::tkeep_t   in_tkeep,
   input  pkt_fifo_pkg::tid_t     in_tid,
   input  pkt_fifo_pkg::tdest_t   in_tdest,
   input  pkt_fifo_pkg::tuser_t   in_tuser,
   input  logic                   in_tlast,

   input  pkt_fifo_pkg::ptr_t     wr_ptr,
   input  pkt_fifo_pkg::ptr_t     rd_ptr,
   input  logic                   rd_req,

   output pkt_fifo_pkg::ptr_t     wr_ptr_p,   // wr_ptr aligned to the RAM write
   output logic                   wr_last_p,

   output logic                   buf_tvalid,
   output pkt_fifo_pkg::tdata_t   buf_tdata,
   output pkt_fifo_pkg::tkeep_t   buf_tkeep,
   output pkt_fifo_pkg::tid_t     buf_tid,
   output pkt_fifo_pkg::tdest_t   buf_tdest,
   output pkt_fifo_pkg::tuser_t   buf_tuser,
   output logic                   buf_tlast
);

   import pkt_fifo_pkg::*;

   // one stage less than the RAM, the array write cycle itself closes the gap
   localparam int WR_STAGES = `PKT_RAM_WR_LAT - 1;
   localparam int RD_STAGES = `PKT_RAM_RD_LAT;

   mem_word_t  wr_data;
   mem_word_t  rd_data;
   logic       wr_en;

   ptr_t       wr_ptr_q  [WR_STAGES];
   logic       wr_last_q [WR_STAGES];
   logic       rd_req_q  [RD_STAGES];

   assign wr_en   = in_tvalid && in_tready;
   assign wr_data = {in_tlast, in_tid, in_tdest, in_tuser, in_tkeep, in_tdata};

   // ------------------------------------------------------------------------
   // write side pipeline
   // ------------------------------------------------------------------------
   always_ff @(posedge axi4s_in) begin
      if (srst) begin
         for (int i = 0; i < WR_STAGES; i++) begin
            wr_ptr_q[i]  <= '0;
            wr_last_q[i] <= 1'b0;
         end
      end else begin
         wr_ptr_q[0]  <= wr_ptr;
         wr_last_q[0] <= wr_en && in_tlast;   // end of packet written
         for (int i = 1; i < WR_STAGES; i++) begin
            wr_ptr_q[i]  <= wr_ptr_q[i-1];
            wr_last_q[i] <= wr_last_q[i-1];
         end
      end
   end

   assign wr_ptr_p  = wr_ptr_q[WR_STAGES-1];
   assign wr_last_p = wr_last_q[WR_STAGES-1];

   sdp_ram u_sdp_ram (
      .axi4s_in (axi4s_in),
      .srst     (srst),
      .wr_req   (wr_en),
      .wr_addr  (wr_ptr[`PKT_ADDR_WID-1:0]),
      .wr_data  (wr_data),
      .rd_req   (rd_req),
      .rd_addr  (rd_ptr[`PKT_ADDR_WID-1:0]),
      .rd_data  (rd_data)
   );

   // ------------------------------------------------------------------------
   // read side, valid follows rd_req by the RAM read latency
   // ------------------------------------------------------------------------
   always_ff @(posedge axi4s_in) begin
      if (srst) begin
         for (int i = 0; i < RD_STAGES; i++) rd_req_q[i] <= 1'b0;
      end else begin
         rd_req_q[0] <= rd_req;
         for (int i = 1; i < RD_STAGES; i++) rd_req_q[i] <= rd_req_q[i-1];
      end
   end

   assign buf_tvalid = rd_req_q[RD_STAGES-1];
   assign {buf_tlast, buf_tid, buf_tdest, buf_tuser, buf_tkeep, buf_tdata} = rd_data;

   // reads only target entries that have already left the write pipeline
   a_rd_behind_wr: assert property (@(posedge axi4s_in) disable iff (srst)
      rd_req |-> (rd_ptr != wr_ptr_p))
      else $error("read issued at the pipelined write pointer");

endmodule

//--- pkt_ptr_ctr.sv
// write, read and commit pointers
`timescale 1ns/10ps

`include "pkt_fifo_consts.svh"

module pkt_ptr_ctr (
   input  logic                 axi4s_in,
   input  logic                 srst,
   input  logic                 in_tvalid,
   output logic                 in_tready,
   input  pkt_fifo_pkg::ptr_t   wr_ptr_p,
   input  logic                 wr_last_p,
   input  logic                 rd_req,
   output pkt_fifo_pkg::ptr_t   wr_ptr,
   output pkt_fifo_pkg::ptr_t   rd_ptr,
   output pkt_fifo_pkg::ptr_t   commit_ptr
);

   import pkt_fifo_pkg::*;

   localparam ptr_t RAM_DEPTH = ptr_t'(2**`PKT_ADDR_WID);

   logic addr_eq;
   logic wrap_ne;
   logic full;

   // same slot, different lap
   assign addr_eq   = (wr_ptr[`PKT_ADDR_WID-1:0] == rd_ptr[`PKT_ADDR_WID-1:0]);
   assign wrap_ne   = (wr_ptr[`PKT_ADDR_WID] != rd_ptr[`PKT_ADDR_WID]);
   assign full      = addr_eq && wrap_ne;
   assign in_tready = !full;

   always_ff @(posedge axi4s_in) begin
      if (srst) begin
         wr_ptr <= '0;
      end else if (in_tvalid && in_tready) begin
         wr_ptr <= wr_ptr + 1'b1;
      end
   end

   always_ff @(posedge axi4s_in) begin
      if (srst) begin
         rd_ptr <= '0;
      end else if (rd_req) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // ------------------------------------------------------------------------
   // commit, the packet is released once its tlast beat is in the RAM
   // ------------------------------------------------------------------------
   always_ff @(posedge axi4s_in) begin
      if (srst) begin
         commit_ptr <= '0;
      end else if (wr_last_p) begin
         commit_ptr <= wr_ptr_p + 1'b1;   // one past the tlast beat
      end
   end

   // committed minus read never exceeds the RAM, so rd_ptr stays behind
   a_rd_not_past_commit: assert property (@(posedge axi4s_in) disable iff (srst)
      ptr_t'(commit_ptr - rd_ptr) <= RAM_DEPTH)
      else $error("rd_ptr has passed commit_ptr");

endmodule

//--- pkt_rd_fsm.sv
// read request FSM
`timescale 1ns/10ps

`include "pkt_fifo_consts.svh"

module pkt_rd_fsm (
   input  logic                                axi4s_in,
   input  logic                                srst,
   input  pkt_fifo_pkg::ptr_t                  rd_ptr,
   input  pkt_fifo_pkg::ptr_t                  commit_ptr,
   input  logic [$clog2(`PKT_SKID_DEPTH):0]    skid_free,
   input  logic                                buf_tvalid,
   output logic                                rd_req
);

   import pkt_fifo_pkg::*;

   localparam int CNT_WID = $clog2(`PKT_SKID_DEPTH) + 1;

   rd_state_t           state;
   rd_state_t           state_nxt;
   logic [CNT_WID-1:0]  in_flight;   // reads issued, not yet out of the RAM
   logic                avail;
   logic                credit;

   assign avail  = (rd_ptr != commit_ptr);
   assign credit = (in_flight < skid_free);   // skid space reserved at issue
   assign rd_req = (state == RD_STREAM) && avail && credit;

   always_comb begin
      state_nxt = state;
      case (state)
         RD_IDLE:        if (avail) state_nxt = RD_STREAM;
         RD_STREAM: begin
            if (!avail) begin
               state_nxt = RD_IDLE;
            end else if (!credit) begin
               state_nxt = RD_WAIT_CREDIT;
            end
         end
         RD_WAIT_CREDIT: if (credit) state_nxt = RD_STREAM;
         default:        state_nxt = RD_IDLE;
      endcase
   end

   always_ff @(posedge axi4s_in) begin
      if (srst) begin
         state <= RD_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_ff @(posedge axi4s_in) begin
      if (srst) begin
         in_flight <= '0;
      end else begin
         case ({rd_req, buf_tvalid})
            2'b10:   in_flight <= in_flight + 1'b1;
            2'b01:   in_flight <= in_flight - 1'b1;
            default: in_flight <= in_flight;   // both or neither
         endcase
      end
   end

endmodule

//--- out_skid.sv
// output skid FIFO
`timescale 1ns/10ps

`include "pkt_fifo_consts.svh"

module out_skid (
   input  logic                                axi4s_in,
   input  logic                                srst,
   input  logic                                buf_tvalid,
   input  pkt_fifo_pkg::tdata_t                buf_tdata,
   input  pkt_fifo_pkg::tkeep_t                buf_tkeep,
   input  pkt_fifo_pkg::tid_t                  buf_tid,
   input  pkt_fifo_pkg::tdest_t                buf_tdest,
   input  pkt_fifo_pkg::tuser_t                buf_tuser,
   input  logic                                buf_tlast,
   output logic [$clog2(`PKT_SKID_DEPTH):0]    skid_free,
   output logic                                axi4s_out_tvalid,
   input  logic                                axi4s_out_tready,
   output pkt_fifo_pkg::tdata_t                axi4s_out_tdata,
   output pkt_fifo_pkg::tkeep_t                axi4s_out_tkeep,
   output pkt_fifo_pkg::tid_t                  axi4s_out_tid,
   output pkt_fifo_pkg::tdest_t                axi4s_out_tdest,
   output pkt_fifo_pkg::tuser_t                axi4s_out_tuser,
   output logic                                axi4s_out_tlast
);

   import pkt_fifo_pkg::*;

   localparam int IDX_WID = $clog2(`PKT_SKID_DEPTH);
   localparam int CNT_WID = IDX_WID + 1;

   mem_word_t           fifo_mem [`PKT_SKID_DEPTH];
   mem_word_t           push_word;
   mem_word_t           out_word;   // output register
   logic [IDX_WID-1:0]  wr_idx;
   logic [IDX_WID-1:0]  rd_idx;
   logic [CNT_WID-1:0]  count;
   logic                pull;

   assign push_word = {buf_tlast, buf_tid, buf_tdest, buf_tuser, buf_tkeep, buf_tdata};
   assign pull      = (count != '0) && (!axi4s_out_tvalid || axi4s_out_tready);
   assign skid_free = CNT_WID'(`PKT_SKID_DEPTH) - count;

   always_ff @(posedge axi4s_in) begin
      if (buf_tvalid) fifo_mem[wr_idx] <= push_word;
      if (pull)       out_word <= fifo_mem[rd_idx];
   end

   // ------------------------------------------------------------------------
   // indices, occupancy and output valid
   // ------------------------------------------------------------------------
   always_ff @(posedge axi4s_in) begin
      if (srst) begin
         wr_idx           <= '0;
         rd_idx           <= '0;
         count            <= '0;
         axi4s_out_tvalid <= 1'b0;
      end else begin
         if (buf_tvalid) wr_idx <= wr_idx + 1'b1;
         if (pull)       rd_idx <= rd_idx + 1'b1;
         case ({buf_tvalid, pull})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         if (pull) begin
            axi4s_out_tvalid <= 1'b1;
         end else if (axi4s_out_tready) begin
            axi4s_out_tvalid <= 1'b0;   // beat taken, nothing behind it
         end
      end
   end

   assign {axi4s_out_tlast, axi4s_out_tid, axi4s_out_tdest, axi4s_out_tuser,
           axi4s_out_tkeep, axi4s_out_tdata} = out_word;

   // read credit in the FSM must keep the FIFO from overflowing
   a_no_push_full: assert property (@(posedge axi4s_in) disable iff (srst)
      buf_tvalid |-> (count < CNT_WID'(`PKT_SKID_DEPTH)))
      else $error("beat pushed into a full output FIFO");

endmodule

//--- pkt_fifo_top.sv
// store-and-forward packet FIFO
`timescale 1ns/10ps

`include "pkt_fifo_consts.svh"

module pkt_fifo_top (
   input  logic                   axi4s_in,
   input  logic                   srst,

   input  logic                   axi4s_in_tvalid,
   output logic                   axi4s_in_tready,
   input  pkt_fifo_pkg::tdata_t   axi4s_in_tdata,
   input  pkt_fifo_pkg::tkeep_t   axi4s_in_tkeep,
   input  pkt_fifo_pkg::tid_t     axi4s_in_tid,
   input  pkt_fifo_pkg::tdest_t   axi4s_in_tdest,
   input  pkt_fifo_pkg::tuser_t   axi4s_in_tuser,
   input  logic                   axi4s_in_tlast,

   output logic                   axi4s_out_tvalid,
   input  logic                   axi4s_out_tready,
   output pkt_fifo_pkg::tdata_t   axi4s_out_tdata,
   output pkt_fifo_pkg::tkeep_t   axi4s_out_tkeep,
   output pkt_fifo_pkg::tid_t     axi4s_out_tid,
   output pkt_fifo_pkg::tdest_t   axi4s_out_tdest,
   output pkt_fifo_pkg::tuser_t   axi4s_out_tuser,
   output logic                   axi4s_out_tlast
);

   import pkt_fifo_pkg::*;

   ptr_t    wr_ptr;
   ptr_t    rd_ptr;
   ptr_t    commit_ptr;
   ptr_t    wr_ptr_p;
   logic    wr_last_p;
   logic    rd_req;

   // buffer to skid
   logic    buf_tvalid;
   tdata_t  buf_tdata;
   tkeep_t  buf_tkeep;
   tid_t    buf_tid;
   tdest_t  buf_tdest;
   tuser_t  buf_tuser;
   logic    buf_tlast;

   logic [$clog2(`PKT_SKID_DEPTH):0] skid_free;

   pkt_ptr_ctr u_pkt_ptr_ctr (
      .axi4s_in   (axi4s_in),
      .srst       (srst),
      .in_tvalid  (axi4s_in_tvalid),
      .in_tready  (axi4s_in_tready),
      .wr_ptr_p   (wr_ptr_p),
      .wr_last_p  (wr_last_p),
      .rd_req     (rd_req),
      .wr_ptr     (wr_ptr),
      .rd_ptr     (rd_ptr),
      .commit_ptr (commit_ptr)
   );

   pkt_buffer u_pkt_buffer (
      .axi4s_in   (axi4s_in),
      .srst       (srst),
      .in_tvalid  (axi4s_in_tvalid),
      .in_tready  (axi4s_in_tready),
      .in_tdata   (axi4s_in_tdata),
      .in_tkeep   (axi4s_in_tkeep),
      .in_tid     (axi4s_in_tid),
      .in_tdest   (axi4s_in_tdest),
      .in_tuser   (axi4s_in_tuser),
      .in_tlast   (axi4s_in_tlast),
      .wr_ptr     (wr_ptr),
      .rd_ptr     (rd_ptr),
      .rd_req     (rd_req),
      .wr_ptr_p   (wr_ptr_p),
      .wr_last_p  (wr_last_p),
      .buf_tvalid (buf_tvalid),
      .buf_tdata  (buf_tdata),
      .buf_tkeep  (buf_tkeep),
      .buf_tid    (buf_tid),
      .buf_tdest  (buf_tdest),
      .buf_tuser  (buf_tuser),
      .buf_tlast  (buf_tlast)
   );

   pkt_rd_fsm u_pkt_rd_fsm (
      .axi4s_in   (axi4s_in),
      .srst       (srst),
      .rd_ptr     (rd_ptr),
      .commit_ptr (commit_ptr),
      .skid_free  (skid_free),
      .buf_tvalid (buf_tvalid),
      .rd_req     (rd_req)
   );

   out_skid u_out_skid (
      .axi4s_in         (axi4s_in),
      .srst             (srst),
      .buf_tvalid       (buf_tvalid),
      .buf_tdata        (buf_tdata),
      .buf_tkeep        (buf_tkeep),
      .buf_tid          (buf_tid),
      .buf_tdest        (buf_tdest),
      .buf_tuser        (buf_tuser),
      .buf_tlast        (buf_tlast),
      .skid_free        (skid_free),
      .axi4s_out_tvalid (axi4s_out_tvalid),
      .axi4s_out_tready (axi4s_out_tready),
      .axi4s_out_tdata  (axi4s_out_tdata),
      .axi4s_out_tkeep  (axi4s_out_tkeep),
      .axi4s_out_tid    (axi4s_out_tid),
      .axi4s_out_tdest  (axi4s_out_tdest),
      .axi4s_out_tuser  (axi4s_out_tuser),
      .axi4s_out_tlast  (axi4s_out_tlast)
   );

endmodule

//--- tb_clk_gen.sv
// testbench clock and reset
`timescale 1ns/10ps

module tb_clk_gen (
   output logic axi4s_in,
   output logic srst
);

   localparam int HALF_PERIOD = 10;   // 20 ns clock
   localparam int RST_CYCLES  = 8;

   initial begin
      axi4s_in = 1'b0;
      forever #(HALF_PERIOD) axi4s_in = ~axi4s_in;
   end

   // released on a falling edge, like every other DUT input
   initial begin
      srst = 1'b1;
      repeat (RST_CYCLES) @(posedge axi4s_in);
      @(negedge axi4s_in);
      srst = 1'b0;
   end

endmodule

//--- pkt_fifo_checker.sv
// packet FIFO scoreboard
`timescale 1ns/10ps

`include "pkt_fifo_consts.svh"

module pkt_fifo_checker (
   input  logic                          axi4s_in,
   input  logic                          srst,
   input  logic                          in_tvalid,
   input  logic                          in_tready,
   input  logic [`PKT_DATA_BYTES*8-1:0]  in_tdata,
   input  logic [`PKT_DATA_BYTES-1:0]    in_tkeep,
   input  logic [`PKT_TID_WID-1:0]       in_tid,
   input  logic [`PKT_TDEST_WID-1:0]     in_tdest,
   input  logic [`PKT_TUSER_WID-1:0]     in_tuser,
   input  logic                          in_tlast,
   input  logic                          out_tvalid,
   input  logic                          out_tready,
   input  logic [`PKT_DATA_BYTES*8-1:0]  out_tdata,
   input  logic [`PKT_DATA_BYTES-1:0]    out_tkeep,
   input  logic [`PKT_TID_WID-1:0]       out_tid,
   input  logic [`PKT_TDEST_WID-1:0]     out_tdest,
   input  logic [`PKT_TUSER_WID-1:0]     out_tuser,
   input  logic                          out_tlast,
   input  logic                          test_end,
   input  int                            test_id,
   input  logic                          run_end,
   input  int                            extra_errs,
   output int                            out_cnt,
   output int                            err_cnt
);

   localparam int BEAT_W = 1 + `PKT_TID_WID + `PKT_TDEST_WID + `PKT_TUSER_WID
                           + `PKT_DATA_BYTES*9;

   logic [BEAT_W-1:0]  exp_q [$];   // beats accepted at the input, in order
   int                 pkt_q [$];   // packet number of each queued beat
   logic [BEAT_W-1:0]  got_w;
   logic [BEAT_W-1:0]  exp_w;
   int                 pkt_of;
   int                 pkt_cnt;     // packets whose tlast went in
   int                 test_cnt;
   int                 out_base;
   int                 err_base;

   // ------------------------------------------------------------------------
   // compare on each output transfer, then record the input transfer
   // ------------------------------------------------------------------------
   always @(posedge axi4s_in) begin
      if (srst) begin
         exp_q.delete();
         pkt_q.delete();
         pkt_cnt  = 0;
         test_cnt = 0;
         out_cnt  = 0;
         err_cnt  = 0;
         out_base = 0;
         err_base = 0;
      end else begin
         if (out_tvalid && out_tready) begin
            got_w = {out_tlast, out_tid, out_tdest, out_tuser, out_tkeep, out_tdata};
            if (exp_q.size() == 0) begin
               $display("%0t: output beat %0d has no input beat to match, extra or duplicated",
                        $time, out_cnt);
               err_cnt++;
            end else begin
               exp_w  = exp_q.pop_front();
               pkt_of = pkt_q.pop_front();
               if (pkt_of >= pkt_cnt) begin   // store-and-forward broken
                  $display("%0t: beat of packet %0d came out before its tlast went in",
                           $time, pkt_of);
                  err_cnt++;
               end
               if (got_w !== exp_w) begin
                  $display("CHECK FAILED at %0t: output beat %0d expected %h got %h",
                           $time, out_cnt, exp_w, got_w);
                  err_cnt++;
               end
            end
            out_cnt++;
         end

         if (in_tvalid && in_tready) begin
            exp_q.push_back({in_tlast, in_tid, in_tdest, in_tuser, in_tkeep, in_tdata});
            pkt_q.push_back(pkt_cnt);
            if (in_tlast) pkt_cnt++;
         end

         if (test_end) begin
            test_cnt++;
            $display("test %0d done: %0d beats out, %0d errors", test_id,
                     out_cnt - out_base, err_cnt + extra_errs - err_base);
            out_base = out_cnt;
            err_base = err_cnt + extra_errs;
         end

         if (run_end) begin
            if (exp_q.size() != 0) begin
               $display("%0d beats went in and never came out", exp_q.size());
               err_cnt++;
            end
            $display("run complete: %0d tests, %0d beats, %0d errors",
                     test_cnt, out_cnt, err_cnt + extra_errs);
         end
      end
   end

endmodule

//--- pkt_fifo_tb.sv
// packet FIFO testbench
`timescale 1ns/10ps

`include "pkt_fifo_consts.svh"

module pkt_fifo_tb;

   localparam int DATA_W = `PKT_DATA_BYTES*8;
   localparam int KEEP_W = `PKT_DATA_BYTES;
   localparam int REC_W  = 5;   // words in a test header
   localparam int RUN_W  = 8;   // words in a beat run

   logic                        axi4s_in;
   logic                        srst;
   logic                        axi4s_in_tvalid;
   logic                        axi4s_in_tready;
   logic [DATA_W-1:0]           axi4s_in_tdata;
   logic [KEEP_W-1:0]           axi4s_in_tkeep;
   logic [`PKT_TID_WID-1:0]     axi4s_in_tid;
   logic [`PKT_TDEST_WID-1:0]   axi4s_in_tdest;
   logic [`PKT_TUSER_WID-1:0]   axi4s_in_tuser;
   logic                        axi4s_in_tlast;
   logic                        axi4s_out_tvalid;
   logic                        axi4s_out_tready;
   logic [DATA_W-1:0]           axi4s_out_tdata;
   logic [KEEP_W-1:0]           axi4s_out_tkeep;
   logic [`PKT_TID_WID-1:0]     axi4s_out_tid;
   logic [`PKT_TDEST_WID-1:0]   axi4s_out_tdest;
   logic [`PKT_TUSER_WID-1:0]   axi4s_out_tuser;
   logic                        axi4s_out_tlast;

   logic [31:0]  stim_mem [0:255];
   integer       seed = 32'h62a2_4998;
   int           rec_ptr;
   int           exp_total = 0;   // beats sent so far over all tests
   int           stall_cnt;
   int           tb_err = 0;
   int           limit = 0;
   int           cycle_cnt = 0;
   int           test_id = 0;
   int           chk_out_cnt;
   int           chk_err_cnt;
   logic         test_end;
   logic         run_end;

   tb_clk_gen u_clk_gen (
      .axi4s_in (axi4s_in),
      .srst     (srst)
   );

   pkt_fifo_top u_pkt_fifo_top (
      .axi4s_in         (axi4s_in),
      .srst             (srst),
      .axi4s_in_tvalid  (axi4s_in_tvalid),
      .axi4s_in_tready  (axi4s_in_tready),
      .axi4s_in_tdata   (axi4s_in_tdata),
      .axi4s_in_tkeep   (axi4s_in_tkeep),
      .axi4s_in_tid     (axi4s_in_tid),
      .axi4s_in_tdest   (axi4s_in_tdest),
      .axi4s_in_tuser   (axi4s_in_tuser),
      .axi4s_in_tlast   (axi4s_in_tlast),
      .axi4s_out_tvalid (axi4s_out_tvalid),
      .axi4s_out_tready (axi4s_out_tready),
      .axi4s_out_tdata  (axi4s_out_tdata),
      .axi4s_out_tkeep  (axi4s_out_tkeep),
      .axi4s_out_tid    (axi4s_out_tid),
      .axi4s_out_tdest  (axi4s_out_tdest),
      .axi4s_out_tuser  (axi4s_out_tuser),
      .axi4s_out_tlast  (axi4s_out_tlast)
   );

   pkt_fifo_checker u_checker (
      .axi4s_in   (axi4s_in),
      .srst       (srst),
      .in_tvalid  (axi4s_in_tvalid),
      .in_tready  (axi4s_in_tready),
      .in_tdata   (axi4s_in_tdata),
      .in_tkeep   (axi4s_in_tkeep),
      .in_tid     (axi4s_in_tid),
      .in_tdest   (axi4s_in_tdest),
      .in_tuser   (axi4s_in_tuser),
      .in_tlast   (axi4s_in_tlast),
      .out_tvalid (axi4s_out_tvalid),
      .out_tready (axi4s_out_tready),
      .out_tdata  (axi4s_out_tdata),
      .out_tkeep  (axi4s_out_tkeep),
      .out_tid    (axi4s_out_tid),
      .out_tdest  (axi4s_out_tdest),
      .out_tuser  (axi4s_out_tuser),
      .out_tlast  (axi4s_out_tlast),
      .test_end   (test_end),
      .test_id    (test_id),
      .run_end    (run_end),
      .extra_errs (tb_err),
      .out_cnt    (chk_out_cnt),
      .err_cnt    (chk_err_cnt)
   );

   // beats plus gaps plus stall cycles, times 4, plus slack
   function automatic int calc_limit();
      int n_tests;
      int n_runs;
      int p;
      int total;
      total   = 0;
      p       = 1;
      n_tests = stim_mem[0];
      for (int t = 0; t < n_tests; t++) begin
         if (stim_mem[p+1] == 2) total += stim_mem[p+2];
         n_runs = stim_mem[p+3];
         p += REC_W;
         for (int r = 0; r < n_runs; r++) begin
            total += stim_mem[p+7] * (stim_mem[p] + 1);
            p += RUN_W;
         end
      end
      return total * 4 + 200;
   endfunction

   // one run of beats with data counting up and tlast only on the final beat
   task automatic send_run(input int p, input int mode);
      int                 gap;
      int                 rep;
      int                 rnd;
      logic [DATA_W-1:0]  data;
      rep  = stim_mem[p+7];
      data = stim_mem[p+1][DATA_W-1:0];
      for (int r = 0; r < rep; r++) begin
         gap = stim_mem[p];
         if (mode == 1) begin
            rnd = $random(seed);
            gap += rnd & 1;   // random valid gaps
         end
         if (gap > 0) begin
            axi4s_in_tvalid = 1'b0;
            repeat (gap) @(negedge axi4s_in);
         end
         axi4s_in_tdata  = data + DATA_W'(r);
         axi4s_in_tkeep  = stim_mem[p+2][KEEP_W-1:0];
         axi4s_in_tid    = stim_mem[p+3][`PKT_TID_WID-1:0];
         axi4s_in_tdest  = stim_mem[p+4][`PKT_TDEST_WID-1:0];
         axi4s_in_tuser  = stim_mem[p+5][`PKT_TUSER_WID-1:0];
         axi4s_in_tlast  = stim_mem[p+6][0] && (r == rep - 1);
         axi4s_in_tvalid = 1'b1;
         while (axi4s_in_tready !== 1'b1) begin
            stall_cnt++;
            @(negedge axi4s_in);
         end
         @(negedge axi4s_in);   // taken on the rising edge in between
      end
      axi4s_in_tvalid = 1'b0;
   endtask

   task automatic drive_ready(input int mode, input int stall);
      int left;
      int rnd;
      left = stall;
      while (chk_out_cnt < exp_total) begin
         case (mode)
            1: begin
               rnd = $random(seed);
               axi4s_out_tready = rnd[0];
            end
            2: begin
               axi4s_out_tready = (left == 0);
               if (left > 0) left--;
            end
            default: axi4s_out_tready = 1'b1;
         endcase
         @(negedge axi4s_in);
      end
      axi4s_out_tready = 1'b1;
   endtask

   task automatic check_full(input int beats);
      if (stall_cnt != 0) begin
         $display("input was held off for %0d cycles before the buffer filled", stall_cnt);
         tb_err++;
      end
      if (axi4s_in_tready !== 1'b0) begin
         $display("CHECK FAILED at %0t: tready still high after %0d beats", $time, beats);
         tb_err++;
      end
      while (axi4s_in_tready !== 1'b1) @(negedge axi4s_in);   // reads free space
   endtask

   task automatic run_test();
      int mode;
      int stall;
      int n_runs;
      int full_chk;
      int beats;
      int base;
      test_id  = stim_mem[rec_ptr];
      mode     = stim_mem[rec_ptr+1];
      stall    = stim_mem[rec_ptr+2];
      n_runs   = stim_mem[rec_ptr+3];
      full_chk = stim_mem[rec_ptr+4];
      base     = rec_ptr + REC_W;
      beats    = 0;
      for (int r = 0; r < n_runs; r++) beats += stim_mem[base + r*RUN_W + 7];
      exp_total += beats;
      stall_cnt  = 0;
      fork
         begin
            for (int r = 0; r < n_runs; r++) send_run(base + r*RUN_W, mode);
            if (full_chk != 0) check_full(beats);
         end
         drive_ready(mode, stall);
      join
      rec_ptr  = base + n_runs*RUN_W;
      test_end = 1'b1;
      @(negedge axi4s_in);
      test_end = 1'b0;
   endtask

   // ------------------------------------------------------------------------
   // run limit
   // ------------------------------------------------------------------------
   always @(posedge axi4s_in) begin
      if (limit > 0) begin
         cycle_cnt++;
         if (cycle_cnt > limit) begin
            $display("timeout after %0d cycles, %0d of %0d beats came out",
                     cycle_cnt, chk_out_cnt, exp_total);
            $display(">>> FAIL");
            $finish;
         end
      end
   end

   // ------------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------------
   initial begin
      int n_tests;
      axi4s_in_tvalid  = 1'b0;
      axi4s_in_tdata   = '0;
      axi4s_in_tkeep   = '0;
      axi4s_in_tid     = '0;
      axi4s_in_tdest   = '0;
      axi4s_in_tuser   = '0;
      axi4s_in_tlast   = 1'b0;
      axi4s_out_tready = 1'b1;
      test_end         = 1'b0;
      run_end          = 1'b0;
      $readmemh("pkt_fifo_stim.txt", stim_mem);
      n_tests = stim_mem[0];
      rec_ptr = 1;
      limit   = calc_limit();

      wait (srst === 1'b1);
      wait (srst === 1'b0);
      @(negedge axi4s_in);
      if (axi4s_out_tvalid !== 1'b0 || axi4s_in_tready !== 1'b1) begin
         $display("CHECK FAILED at %0t: after reset out_tvalid %b in_tready %b",
                  $time, axi4s_out_tvalid, axi4s_in_tready);
         tb_err++;
      end
      test_end = 1'b1;   // reset check closes as test 0
      @(negedge axi4s_in);
      test_end = 1'b0;

      for (int t = 0; t < n_tests; t++) run_test();

      run_end = 1'b1;
      @(negedge axi4s_in);
      run_end = 1'b0;
      @(negedge axi4s_in);
      if (chk_err_cnt + tb_err == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

//--- pkt_fifo_stim.txt
// packet FIFO stimulus, all values hex, first value is the number of tests
// test header: id  ready_mode(0 always, 1 random, 2 stall)  stall_cycles  runs  full_check
// beat run:    gap  tdata  tkeep  tid  tdest  tuser  tlast  count
// a run gives count beats with tdata counting up, tlast marks only its final beat
6
// single beat packet
1 0 0 1 0
0 a5a50001 f 1 2 3 1 1
// four beat packet with a short last beat
2 0 0 2 0
0 10000000 f 2 4 6 0 3
0 10000003 3 2 4 6 1 1
// back-to-back packets with gaps
3 0 0 3 0
0 20000000 f 3 5 7 1 2
2 20000010 1 3 6 8 1 1
1 20000020 7 4 6 9 1 5
// random output ready and random input gaps
4 1 0 5 0
0 30000000 f 5 1 0 1 6
0 30000100 3 6 2 1 1 1
3 30000200 f 7 3 2 1 9
0 30000300 f 8 4 3 0 a
0 3000030a c 8 4 3 1 1
// output stalled while three packets queue up
5 2 1e 3 0
0 40000000 f 9 7 a 1 4
0 40000100 f a 8 b 1 2
0 40000200 1 b 9 c 1 1
// one 64 beat packet fills the buffer against a stalled output
6 2 64 1 1
0 c0de0000 f c d e 1 40

//--- compile.f
+incdir+.
pkt_fifo_pkg.sv
sdp_ram.sv
pkt_buffer.sv
pkt_ptr_ctr.sv
pkt_rd_fsm.sv
out_skid.sv
pkt_fifo_top.sv
tb_clk_gen.sv
pkt_fifo_checker.sv
pkt_fifo_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the packet FIFO testbench with Verilator

verilator --binary --timing --assert -Wno-fatal -f compile.f \
   --top-module pkt_fifo_tb -o sim_pkt_fifo > build.log 2>&1 \
   || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_pkt_fifo > sim.log 2>&1

grep -q "^>>> PASS$" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed, see sim.log"; exit 1; }
